// File: list_sched_top.f
+incdir+tests
verilog/sched_pkg.sv
verilog/loop_if.sv
verilog/loop_counter.sv
verilog/sched_fsm.sv
verilog/rank_unit.sv
verilog/rank_sorter.sv
verilog/proc_assigner.sv
verilog/list_sched_top.sv
tests/tb_list_sched.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_list_sched
FILE_LIST = list_sched_top.f
OBJ_DIR = obj_dir
PASS_MSG = === PASS ===

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/sched_ref_model.svh
`ifndef SCHED_REF_MODEL_SVH
`define SCHED_REF_MODEL_SVH

// Behavioral list scheduler, one rule at a time
function automatic void model_schedule(
    input comm_matrix_t c,
    input exec_matrix_t e,
    output proc_vec_t procs,
    output rank_vec_t finish,
    output time_t span
);
    int rank [NUM_TASKS];
    int order [NUM_TASKS];
    int ft [NUM_TASKS];
    int pr [NUM_TASKS];
    int avail [NUM_PROCS];
    int sum, best, key, j, t;
    int ready, arrive, eft, best_ft, best_p, total;

    // Upward rank, last task first so successor ranks exist
    for (int i = NUM_TASKS - 1; i >= 0; i--) begin
        sum = 0;
        for (int p = 0; p < NUM_PROCS; p++) begin
            sum += int'(e[p][i]);
        end
        best = 0;
        for (int s = i + 1; s < NUM_TASKS; s++) begin
            if (c[i][s] != 0 && int'(c[i][s]) + rank[s] > best) begin
                best = int'(c[i][s]) + rank[s];
            end
        end
        rank[i] = sum / NUM_PROCS + best;
    end

    // Insertion sort, descending; equal ranks keep index order
    for (int i = 0; i < NUM_TASKS; i++) begin
        order[i] = i;
    end
    for (int i = 1; i < NUM_TASKS; i++) begin
        key = order[i];
        j = i - 1;
        while (j >= 0 && rank[order[j >= 0 ? j : 0]] < rank[key]) begin
            order[j + 1] = order[j];
            j--;
        end
        order[j + 1] = key;
    end

    // Earliest finish placement
    for (int p = 0; p < NUM_PROCS; p++) begin
        avail[p] = 0;
    end
    total = 0;
    for (int k = 0; k < NUM_TASKS; k++) begin
        t = order[k];
        best_ft = -1;
        best_p = 0;
        for (int p = 0; p < NUM_PROCS; p++) begin
            ready = avail[p];
            for (int a = 0; a < t; a++) begin
                if (c[a][t] != 0) begin
                    // No transfer cost on the same processor
                    arrive = ft[a] + ((pr[a] == p) ? 0 : int'(c[a][t]));
                    ready = (arrive > ready) ? arrive : ready;
                end
            end
            eft = ready + int'(e[p][t]);
            if (best_ft < 0 || eft < best_ft) begin
                best_ft = eft;
                best_p = p;
            end
        end
        pr[t] = best_p;
        ft[t] = best_ft;
        avail[best_p] = best_ft;
        total = (best_ft > total) ? best_ft : total;
    end

    for (int i = 0; i < NUM_TASKS; i++) begin
        procs[i] = proc_id_t'(pr[i]);
        finish[i] = time_t'(ft[i]);
    end
    span = time_t'(total);
endfunction

// Processor with the smallest run time, lowest index on a tie
function automatic int fastest_proc(input exec_matrix_t e, input int t);
    int best;
    best = 0;
    for (int p = 1; p < NUM_PROCS; p++) begin
        if (e[p][t] < e[best][t]) begin
            best = p;
        end
    end
    return best;
endfunction

////////////////////
// Graph generators
////////////////////

// Chain with small costs and one clearly fast processor per task
function automatic void make_chain(output comm_matrix_t c, output exec_matrix_t e);
    c = '0;
    for (int t = 0; t < NUM_TASKS; t++) begin
        if (t < NUM_TASKS - 1) begin
            c[t][t + 1] = cost_t'(1 + t % 3);
        end
        for (int p = 0; p < NUM_PROCS; p++) begin
            e[p][t] = cost_t'((p == t % NUM_PROCS) ? 2 + t % 4 : 30);
        end
    end
endfunction

// Task 0 forks to the middle tasks, which all join into the last one
function automatic void make_fork_join(output comm_matrix_t c, output exec_matrix_t e);
    c = '0;
    for (int t = 1; t < NUM_TASKS - 1; t++) begin
        c[0][t] = cost_t'(40 + 3 * t);
        c[t][NUM_TASKS - 1] = cost_t'(50 - 2 * t);
    end
    for (int t = 0; t < NUM_TASKS; t++) begin
        for (int p = 0; p < NUM_PROCS; p++) begin
            e[p][t] = cost_t'(4 + (3 * t + 5 * p) % 9);
        end
    end
endfunction

// Costs only above the diagonal, run times 1 to 15
function automatic void make_random(
    inout int seed,
    output comm_matrix_t c,
    output exec_matrix_t e
);
    c = '0;
    for (int a = 0; a < NUM_TASKS; a++) begin
        for (int b = a + 1; b < NUM_TASKS; b++) begin
            c[a][b] = cost_t'($unsigned($random(seed)) % 16);
        end
        for (int p = 0; p < NUM_PROCS; p++) begin
            e[p][a] = cost_t'($unsigned($random(seed)) % 15 + 1);
        end
    end
endfunction

`endif

// File: tests/tb_list_sched.sv
`timescale 1ns/10ps

module tb_list_sched;
    import sched_pkg::*;

    localparam int SEED = 32'h5628_8db7;
    localparam int NUM_RANDOM = 20;
    // 25 runs of about 324 cycles, plus reset time and margin
    localparam int CYCLE_LIMIT = 10_000;

    logic clk;
    logic reset;
    logic start;
    comm_matrix_t comm_cost;
    exec_matrix_t exec_time;
    logic done;
    proc_vec_t proc_assign;
    rank_vec_t finish_time;
    time_t makespan;

    int seed;
    int cycle_count = 0;
    string test_name;

    `include "sched_ref_model.svh"

    list_sched_top list_sched_top_inst (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .comm_cost   (comm_cost),
        .exec_time   (exec_time),
        .done        (done),
        .proc_assign (proc_assign),
        .finish_time (finish_time),
        .makespan    (makespan)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    ////////////////////
    // Watchdog
    ////////////////////
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        abort_run($sformatf("Timeout: done did not arrive within %0d cycles", CYCLE_LIMIT));
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            abort_run($sformatf("** Error: %s: %s expected %0d, actual %0d",
                                test_name, what, expected, actual));
        end
    endtask

    ////////////////////
    // Run helpers
    ////////////////////
    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_done();
        while (done !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_outputs();
        proc_vec_t exp_proc;
        rank_vec_t exp_finish;
        time_t exp_span;
        model_schedule(comm_cost, exec_time, exp_proc, exp_finish, exp_span);
        for (int t = 0; t < NUM_TASKS; t++) begin
            assert (int'(proc_assign[t]) < NUM_PROCS) else begin
                abort_run($sformatf("%s: task %0d was placed on processor %0d, which does not exist",
                                    test_name, t, proc_assign[t]));
            end
            check_value($sformatf("proc_assign[%0d]", t), int'(exp_proc[t]),
                        int'(proc_assign[t]));
            check_value($sformatf("finish_time[%0d]", t), int'(exp_finish[t]),
                        int'(finish_time[t]));
        end
        check_value("makespan", int'(exp_span), int'(makespan));
    endtask

    task automatic run_and_compare();
        pulse_start();
        wait_for_done();
        compare_outputs();
    endtask

    initial begin
        seed = SEED;
        reset = 1'b1;
        start = 1'b0;
        comm_cost = '0;
        exec_time = '0;
        test_name = "power_on";
        repeat (4) @(negedge clk);
        reset = 1'b0;

        test_name = "chain";
        make_chain(comm_cost, exec_time);
        run_and_compare();
        for (int t = 0; t < NUM_TASKS; t++) begin
            check_value($sformatf("fastest processor for task %0d", t),
                        fastest_proc(exec_time, t), int'(proc_assign[t]));
        end
        check_value("makespan against last finish", int'(finish_time[NUM_TASKS - 1]),
                    int'(makespan));

        test_name = "fork_join";
        make_fork_join(comm_cost, exec_time);
        run_and_compare();

        for (int n = 0; n < NUM_RANDOM; n++) begin
            test_name = $sformatf("random_%0d", n);
            make_random(seed, comm_cost, exec_time);
            run_and_compare();
        end

        // New start straight from DONE
        test_name = "restart";
        make_random(seed, comm_cost, exec_time);
        pulse_start();
        check_value("done after new start", 0, int'(done));
        wait_for_done();
        compare_outputs();

        test_name = "mid_run_reset";
        make_random(seed, comm_cost, exec_time);
        pulse_start();
        // Reset lands in ASSIGN, after a few tasks are placed
        repeat (200) @(negedge clk);
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        check_value("done after reset", 0, int'(done));
        check_value("makespan after reset", 0, int'(makespan));
        for (int t = 0; t < NUM_TASKS; t++) begin
            check_value($sformatf("proc_assign[%0d] after reset", t), 0, int'(proc_assign[t]));
            check_value($sformatf("finish_time[%0d] after reset", t), 0, int'(finish_time[t]));
        end
        make_random(seed, comm_cost, exec_time);
        run_and_compare();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: verilog/list_sched_top.sv
`timescale 1ns/10ps

module list_sched_top (
    input logic clk,
    input logic reset,
    input logic start,
    input sched_pkg::comm_matrix_t comm_cost,
    input sched_pkg::exec_matrix_t exec_time,
    output logic done,
    output sched_pkg::proc_vec_t proc_assign,
    output sched_pkg::rank_vec_t finish_time,
    output sched_pkg::time_t makespan
);
    import sched_pkg::*;

    loop_if lp ();

    rank_vec_t rank;
    order_vec_t order;

    sched_fsm sched_fsm_inst (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .done  (done),
        .lp    (lp.fsm)
    );

    loop_counter loop_counter_inst (
        .clk   (clk),
        .reset (reset),
        .lp    (lp.counter)
    );

    rank_unit rank_unit_inst (
        .clk       (clk),
        .reset     (reset),
        .lp        (lp.unit),
        .comm_cost (comm_cost),
        .exec_time (exec_time),
        .rank      (rank)
    );

    rank_sorter rank_sorter_inst (
        .clk   (clk),
        .reset (reset),
        .lp    (lp.unit),
        .rank  (rank),
        .order (order)
    );

    proc_assigner proc_assigner_inst (
        .clk         (clk),
        .reset       (reset),
        .lp          (lp.unit),
        .comm_cost   (comm_cost),
        .exec_time   (exec_time),
        .order       (order),
        .proc_assign (proc_assign),
        .finish_time (finish_time),
        .makespan    (makespan)
    );

endmodule

// File: verilog/proc_assigner.sv
`timescale 1ns/10ps

module proc_assigner (
    input logic clk,
    input logic reset,
    loop_if.unit lp,
    input sched_pkg::comm_matrix_t comm_cost,
    input sched_pkg::exec_matrix_t exec_time,
    input sched_pkg::order_vec_t order,
    output sched_pkg::proc_vec_t proc_assign,
    output sched_pkg::rank_vec_t finish_time,
    output sched_pkg::time_t makespan
);
    import sched_pkg::*;

    logic active;
    logic is_pred;
    logic remote;
    logic take;
    task_id_t cur_task;
    task_id_t pred;
    proc_id_t cand;
    time_t [NUM_PROCS-1:0] avail;
    time_t pred_max;
    time_t pred_base;
    time_t arrival;
    time_t pred_next;
    time_t est;
    time_t eft;
    time_t best_ft;
    proc_id_t best_proc;
    time_t win_ft;
    proc_id_t win_proc;

    assign active = lp.run && (lp.phase == ASSIGN);

    // Outer walks priority slots, middle the candidate, inner the predecessor
    assign cur_task = order[lp.outer_idx];
    assign cand = lp.mid_idx;
    assign pred = lp.inner_idx;

    ////////////////////
    // Ready time from predecessors
    ////////////////////
    assign is_pred = (comm_cost[pred][cur_task] != '0);
    // Same processor means no transfer
    assign remote = (proc_assign[pred] != cand);
    assign arrival = finish_time[pred] +
                     (remote ? time_t'(comm_cost[pred][cur_task]) : '0);

    assign pred_base = (lp.inner_idx == '0) ? '0 : pred_max;
    assign pred_next = (is_pred && (arrival > pred_base)) ? arrival : pred_base;

    assign est = (pred_next > avail[cand]) ? pred_next : avail[cand];
    assign eft = est + time_t'(exec_time[cand][cur_task]);

    ////////////////////
    // Best candidate so far
    ////////////////////
    // First candidate always wins, later ones only when strictly earlier
    assign take = (lp.mid_idx == '0) || (eft < best_ft);
    assign win_ft = take ? eft : best_ft;
    assign win_proc = take ? cand : best_proc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pred_max <= '0;
            best_ft <= '0;
            best_proc <= '0;
            avail <= '0;
            proc_assign <= '0;
            finish_time <= '0;
            makespan <= '0;
        end else if (lp.clear && (lp.phase == IDLE)) begin
            // Fresh tables for a new run
            avail <= '0;
            proc_assign <= '0;
            finish_time <= '0;
            makespan <= '0;
        end else if (active) begin
            pred_max <= pred_next;
            if (lp.inner_last) begin
                best_ft <= win_ft;
                best_proc <= win_proc;
            end
            if (lp.mid_last) begin
                proc_assign[cur_task] <= win_proc;
                finish_time[cur_task] <= win_ft;
                avail[win_proc] <= win_ft;
                if (win_ft > makespan) begin
                    makespan <= win_ft;
                end
            end
        end
    end

endmodule

// File: verilog/rank_sorter.sv
`timescale 1ns/10ps

module rank_sorter (
    input logic clk,
    input logic reset,
    loop_if.unit lp,
    input sched_pkg::rank_vec_t rank,
    output sched_pkg::order_vec_t order
);
    import sched_pkg::*;

    logic active;
    logic ahead;
    task_id_t cur_task;
    task_id_t other;
    task_id_t cnt;
    task_id_t cnt_base;
    task_id_t cnt_next;

    assign active = lp.run && (lp.phase == SORT);
    assign cur_task = lp.outer_idx;
    assign other = lp.inner_idx;

    ////////////////////
    // Rank counting sort
    ////////////////////

    // Ties go to the lower index, which keeps the order stable
    assign ahead = (rank[other] > rank[cur_task]) ||
                   ((rank[other] == rank[cur_task]) && (other < cur_task));

    assign cnt_base = (lp.inner_idx == '0) ? '0 : cnt;
    assign cnt_next = cnt_base + task_id_t'(ahead);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt <= '0;
            order <= '0;
        end else if (active) begin
            cnt <= cnt_next;
            // Number of tasks ahead is the slot
            if (lp.inner_last) begin
                order[cnt_next] <= cur_task;
            end
        end
    end

endmodule

// File: verilog/rank_unit.sv
`timescale 1ns/10ps

module rank_unit (
    input logic clk,
    input logic reset,
    loop_if.unit lp,
    input sched_pkg::comm_matrix_t comm_cost,
    input sched_pkg::exec_matrix_t exec_time,
    output sched_pkg::rank_vec_t rank
);
    import sched_pkg::*;

    logic active;
    task_id_t cur_task;
    task_id_t succ;
    time_t succ_max;
    time_t max_base;
    time_t edge_val;
    time_t max_next;
    time_t exec_sum;
    time_t avg_exec;

    assign active = lp.run && (lp.phase == RANK);

    // Highest task first so every successor rank is already known
    assign cur_task = LAST_TASK - lp.outer_idx;
    assign succ = lp.inner_idx;

    assign max_base = (lp.inner_idx == '0) ? '0 : succ_max;
    assign edge_val = time_t'(comm_cost[cur_task][succ]) + rank[succ];

    always_comb begin
        max_next = max_base;
        if ((comm_cost[cur_task][succ] != '0) && (edge_val > max_base)) begin
            max_next = edge_val;
        end
    end

    // Mean run time over all processors, truncated
    always_comb begin
        exec_sum = '0;
        for (int p = 0; p < NUM_PROCS; p++) begin
            exec_sum = exec_sum + time_t'(exec_time[p][cur_task]);
        end
        avg_exec = exec_sum / time_t'(NUM_PROCS);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            succ_max <= '0;
            rank <= '0;
        end else if (active) begin
            succ_max <= max_next;
            if (lp.inner_last) begin
                rank[cur_task] <= avg_exec + max_next;
            end
        end
    end

endmodule

// File: verilog/sched_fsm.sv
`timescale 1ns/10ps

module sched_fsm (
    input logic clk,
    input logic reset,
    input logic start,
    output logic done,
    loop_if.fsm lp
);
    import sched_pkg::*;

    phase_t state;
    logic pending;

    assign lp.phase = state;
    assign lp.run = (state == RANK) || (state == SORT) || (state == ASSIGN);

    // Zero the indices just before every phase entry
    assign lp.clear = pending || lp.outer_last;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            pending <= 1'b0;
            done <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (pending) begin
                        state <= RANK;
                        pending <= 1'b0;
                    end else if (start) begin
                        pending <= 1'b1;
                    end
                end
                RANK: begin
                    if (lp.outer_last) begin
                        state <= SORT;
                    end
                end
                SORT: begin
                    if (lp.outer_last) begin
                        state <= ASSIGN;
                    end
                end
                ASSIGN: begin
                    if (lp.outer_last) begin
                        state <= DONE;
                        done <= 1'b1;
                    end
                end
                DONE: begin
                    // New run without reset, result drops with done
                    if (start) begin
                        state <= IDLE;
                        pending <= 1'b1;
                        done <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: verilog/loop_counter.sv
`timescale 1ns/10ps

module loop_counter (
    input logic clk,
    input logic reset,
    loop_if.counter lp
);
    import sched_pkg::*;

    proc_id_t mid_final;

    // Middle loop walks processors only while placing tasks
    assign mid_final = (lp.phase == ASSIGN) ? LAST_PROC : '0;

    assign lp.inner_last = lp.run && (lp.inner_idx == LAST_TASK);
    assign lp.mid_last = lp.inner_last && (lp.mid_idx == mid_final);
    assign lp.outer_last = lp.mid_last && (lp.outer_idx == LAST_TASK);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lp.outer_idx <= '0;
            lp.mid_idx <= '0;
            lp.inner_idx <= '0;
        end else if (lp.clear) begin
            lp.outer_idx <= '0;
            lp.mid_idx <= '0;
            lp.inner_idx <= '0;
        end else if (lp.run) begin
            if (lp.inner_last) begin
                lp.inner_idx <= '0;
                if (lp.mid_last) begin
                    lp.mid_idx <= '0;
                    // Outer wraps on its own strobe
                    if (lp.outer_last) begin
                        lp.outer_idx <= '0;
                    end else begin
                        lp.outer_idx <= lp.outer_idx + 1'b1;
                    end
                end else begin
                    lp.mid_idx <= lp.mid_idx + 1'b1;
                end
            end else begin
                lp.inner_idx <= lp.inner_idx + 1'b1;
            end
        end
    end

endmodule

// File: verilog/loop_if.sv
`timescale 1ns/10ps

interface loop_if;
    import sched_pkg::*;

    // Phase control from the FSM
    phase_t phase;
    logic clear;
    logic run;

    // Nested indices, outer to inner
    task_id_t outer_idx;
    proc_id_t mid_idx;
    task_id_t inner_idx;

    // Wrap strobes, each implies the ones inside it
    logic inner_last;
    logic mid_last;
    logic outer_last;

    modport fsm (output phase, output clear, output run, input outer_last);

    modport counter (
        input phase, input clear, input run,
        output outer_idx, output mid_idx, output inner_idx,
        output inner_last, output mid_last, output outer_last
    );

    modport unit (
        input phase, input clear, input run,
        input outer_idx, input mid_idx, input inner_idx,
        input inner_last, input mid_last, input outer_last
    );

endinterface

// File: verilog/sched_pkg.sv
package sched_pkg;

    ////////////////////
    // Graph and machine sizes
    ////////////////////
    localparam int NUM_TASKS = 8;
    localparam int NUM_PROCS = 3;
    localparam int COST_W = 8;
    localparam int TIME_W = 16;
    localparam int TASK_W = $clog2(NUM_TASKS);
    localparam int PROC_W = $clog2(NUM_PROCS);

    typedef logic [TASK_W-1:0] task_id_t;
    typedef logic [PROC_W-1:0] proc_id_t;
    typedef logic [COST_W-1:0] cost_t;
    typedef logic [TIME_W-1:0] time_t;

    // Final index values, used for the wrap strobes
    localparam task_id_t LAST_TASK = task_id_t'(NUM_TASKS - 1);
    localparam proc_id_t LAST_PROC = proc_id_t'(NUM_PROCS - 1);

    // comm[a][b] is the cost of edge a -> b, zero means no edge
    typedef cost_t [NUM_TASKS-1:0][NUM_TASKS-1:0] comm_matrix_t;
    // exec[p][t] is the run time of task t on processor p
    typedef cost_t [NUM_PROCS-1:0][NUM_TASKS-1:0] exec_matrix_t;

    typedef time_t [NUM_TASKS-1:0] rank_vec_t;
    typedef task_id_t [NUM_TASKS-1:0] order_vec_t;
    typedef proc_id_t [NUM_TASKS-1:0] proc_vec_t;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        RANK   = 3'd1,
        SORT   = 3'd2,
        ASSIGN = 3'd3,
        DONE   = 3'd4
    } phase_t;

endpackage
